/* src/aui_params_pkg.sv */
package aui_params_pkg;

    // Lane layout of the attachment unit interface
    localparam int NUM_LANES = 16;

    // One symbol per lane per beat
    localparam int SYMBOL_WIDTH = 10;

    // Alignment marker format
    localparam int MARKER_WIDTH = 120;
    localparam int MARKER_SYMBOLS = MARKER_WIDTH / SYMBOL_WIDTH;

    // Frame made of marker beats followed by filler beats
    localparam int FRAME_BEATS = 32;
    localparam int BEAT_IDX_WIDTH = $clog2(FRAME_BEATS);

    // Data blocks are sent as all ones
    localparam logic [SYMBOL_WIDTH-1:0] FILL_SYMBOL = '1;

endpackage

/* src/aui_types_pkg.sv */
package aui_types_pkg;

    import aui_params_pkg::*;

    // Single 10-bit lane symbol
    typedef logic [SYMBOL_WIDTH-1:0] symbol_t;

    // Lane 0 sits in the lowest slot
    typedef symbol_t [NUM_LANES-1:0] lane_symbols_t;

    // Descriptor passed from sequencer to formatter
    typedef struct packed {
        logic [BEAT_IDX_WIDTH-1:0] beat_idx;
        logic                      is_marker;
        logic                      sync;
    } beat_desc_t;

    // Output beat of the inserter
    typedef struct packed {
        lane_symbols_t symbols;
        logic          sync;
    } aui_beat_t;

    // Sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE   = 2'd0,
        SEQ_MARKER = 2'd1,
        SEQ_FILL   = 2'd2
    } seq_state_e;

endpackage

/* src/am_table.sv */
module am_table (
    input  logic                                       clk,
    input  logic                                       i_load,
    input  logic [aui_params_pkg::BEAT_IDX_WIDTH-1:0]  i_symbol_idx,
    output aui_types_pkg::lane_symbols_t               o_symbols
);

    import aui_params_pkg::*;

    // Per-lane alignment markers as transmitted on the wire
    localparam logic [MARKER_WIDTH-1:0] AM_RAW [NUM_LANES] = '{
        120'h9a4a26b665b5d9d9fe8e0c260171f3,
        120'h9a4a260465b5d967a52181985ade7e,
        120'h9a4a264665b5d9fec10ca9013ef356,
        120'h9a4a265a65b5d984797f2f7b8680d0,
        120'h9a4a26e165b5d919d5ae0de62a51f2,
        120'h9a4a26f265b5d94eedb02eb1124fd1,
        120'h9a4a263d65b5d9eebd635e11429ca1,
        120'h9a4a262265b5d9322989a4cdd6765b,
        120'h9a4a266065b5d99f1e8c8a60e17375,
        120'h9a4a266b65b5d9a28e3bc35d71c43c,
        120'h9a4a26fa65b5d9046a1427fb95ebd8,
        120'h9a4a266c65b5d971dd99c78e226638,
        120'h9a4a261865b5d95b5d096aa4a2f695,
        120'h9a4a261465b5d9ccce683c333197c3,
        120'h9a4a26d065b5d9b13504594ecafba6,
        120'h9a4a26b465b5d956594586a9a6ba79
    };

    logic [MARKER_WIDTH-1:0] am_rework [NUM_LANES];

    function automatic logic [7:0] reverse_octet(input logic [7:0] octet);
        logic [7:0] flipped;
        for (int b = 0; b < 8; b++) begin
            flipped[b] = octet[7-b];
        end
        return flipped;
    endfunction

    // Octet order reversed and each octet bit-flipped
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int o = 0; o < MARKER_WIDTH / 8; o++) begin
                am_rework[l][(MARKER_WIDTH/8 - 1 - o)*8 +: 8] =
                    reverse_octet(AM_RAW[l][o*8 +: 8]);
            end
        end
    end

    // Symbol b of a lane is bits 10b to 10b+9 of its reworked marker
    always_ff @(posedge clk) begin
        if (i_load && (i_symbol_idx < MARKER_SYMBOLS)) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                o_symbols[l] <= am_rework[l][i_symbol_idx*SYMBOL_WIDTH +: SYMBOL_WIDTH];
            end
        end
    end

endmodule

/* src/frame_sequencer.sv */
module frame_sequencer (
    input  logic                       clk,
    input  logic                       rst,
    output aui_types_pkg::beat_desc_t  o_desc,
    output logic                       o_valid,
    input  logic                       i_ready
);

    import aui_params_pkg::*;
    import aui_types_pkg::*;

    seq_state_e                state;
    seq_state_e                state_next;
    logic [BEAT_IDX_WIDTH-1:0] beat_idx;
    logic [BEAT_IDX_WIDTH-1:0] beat_next;
    logic                      accept;

    assign o_valid = (state != SEQ_IDLE);
    assign accept  = o_valid && i_ready;

    // Frames follow each other with no gap
    always_comb begin
        if (beat_idx == BEAT_IDX_WIDTH'(FRAME_BEATS - 1)) begin
            beat_next = '0;
        end else begin
            beat_next = beat_idx + 1'b1;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            SEQ_IDLE: begin
                state_next = SEQ_MARKER;
            end
            SEQ_MARKER, SEQ_FILL: begin
                if (accept) begin
                    if (beat_next < MARKER_SYMBOLS) begin
                        state_next = SEQ_MARKER;
                    end else begin
                        state_next = SEQ_FILL;
                    end
                end
            end
            default: begin
                state_next = SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= SEQ_IDLE;
            beat_idx <= '0;
        end else begin
            state <= state_next;
            if (accept) begin
                beat_idx <= beat_next;
            end
        end
    end

    // Flags decoded from the beat index
    always_comb begin
        o_desc.beat_idx  = beat_idx;
        o_desc.is_marker = (beat_idx < MARKER_SYMBOLS);
        o_desc.sync      = (beat_idx == '0);
    end

    // Descriptor is held until the formatter takes it
    desc_hold_a: assert property (
        @(posedge clk) disable iff (rst)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_desc))
    );

endmodule

/* src/lane_formatter.sv */
module lane_formatter (
    input  logic                       clk,
    input  logic                       rst,
    input  aui_types_pkg::beat_desc_t  i_desc,
    input  logic                       i_valid,
    output logic                       o_ready,
    output aui_types_pkg::aui_beat_t   o_beat,
    output logic                       o_valid,
    input  logic                       i_ready
);

    import aui_params_pkg::*;
    import aui_types_pkg::*;

    logic          accept;
    logic          beat_valid;
    logic          is_marker_q;
    logic          sync_q;
    lane_symbols_t table_symbols;
    lane_symbols_t beat_symbols;

    // Output register is free when empty or draining this cycle
    assign o_ready = !beat_valid || i_ready;
    assign accept  = i_valid && o_ready;

    // Table read lands in the same cycle as the flags below
    am_table u_am_table (
        .clk          (clk),
        .i_load       (accept),
        .i_symbol_idx (i_desc.beat_idx),
        .o_symbols    (table_symbols)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_valid <= 1'b0;
        end else if (accept) begin
            beat_valid <= 1'b1;
        end else if (i_ready) begin
            beat_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            is_marker_q <= i_desc.is_marker;
            sync_q      <= i_desc.sync;
        end
    end

    // Marker symbol or all-ones filler on every lane
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            if (is_marker_q) begin
                beat_symbols[l] = table_symbols[l];
            end else begin
                beat_symbols[l] = FILL_SYMBOL;
            end
        end
    end

    always_comb begin
        o_beat.symbols = beat_symbols;
        o_beat.sync    = sync_q;
    end

    assign o_valid = beat_valid;

    beat_hold_a: assert property (
        @(posedge clk) disable iff (rst)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_beat))
    );

    // Frame start is always a marker beat
    sync_on_marker_a: assert property (
        @(posedge clk) disable iff (rst)
        (o_valid && o_beat.sync) |-> is_marker_q
    );

endmodule

/* src/aui_am_inserter.sv */
module aui_am_inserter (
    input  logic                      clk,
    input  logic                      rst,
    output aui_types_pkg::aui_beat_t  o_beat,
    output logic                      o_valid,
    input  logic                      i_ready
);

    import aui_types_pkg::*;

    beat_desc_t desc;
    logic       desc_valid;
    logic       desc_ready;

    // Beat descriptors in frame order
    frame_sequencer u_frame_sequencer (
        .clk     (clk),
        .rst     (rst),
        .o_desc  (desc),
        .o_valid (desc_valid),
        .i_ready (desc_ready)
    );

    // Lane symbols and the output register
    lane_formatter u_lane_formatter (
        .clk     (clk),
        .rst     (rst),
        .i_desc  (desc),
        .i_valid (desc_valid),
        .o_ready (desc_ready),
        .o_beat  (o_beat),
        .o_valid (o_valid),
        .i_ready (i_ready)
    );

endmodule

/* verification/aui_am_model.svh */
`ifndef AUI_AM_MODEL_SVH
`define AUI_AM_MODEL_SVH

// Raw per-lane markers of the reference, lane 0 first
localparam logic [MARKER_WIDTH-1:0] REF_AM_RAW [NUM_LANES] = '{
    120'h9a4a26b665b5d9d9fe8e0c260171f3,
    120'h9a4a260465b5d967a52181985ade7e,
    120'h9a4a264665b5d9fec10ca9013ef356,
    120'h9a4a265a65b5d984797f2f7b8680d0,
    120'h9a4a26e165b5d919d5ae0de62a51f2,
    120'h9a4a26f265b5d94eedb02eb1124fd1,
    120'h9a4a263d65b5d9eebd635e11429ca1,
    120'h9a4a262265b5d9322989a4cdd6765b,
    120'h9a4a266065b5d99f1e8c8a60e17375,
    120'h9a4a266b65b5d9a28e3bc35d71c43c,
    120'h9a4a26fa65b5d9046a1427fb95ebd8,
    120'h9a4a266c65b5d971dd99c78e226638,
    120'h9a4a261865b5d95b5d096aa4a2f695,
    120'h9a4a261465b5d9ccce683c333197c3,
    120'h9a4a26d065b5d9b13504594ecafba6,
    120'h9a4a26b465b5d956594586a9a6ba79
};

// Whole marker mirrored bit by bit
function automatic logic [MARKER_WIDTH-1:0] mirror_marker(input logic [MARKER_WIDTH-1:0] raw);
    logic [MARKER_WIDTH-1:0] mirrored;
    for (int i = 0; i < MARKER_WIDTH; i++) begin
        mirrored[i] = raw[MARKER_WIDTH-1-i];
    end
    return mirrored;
endfunction

function automatic symbol_t expected_symbol(input int lane, input int beat);
    logic [MARKER_WIDTH-1:0] mirrored;
    mirrored = mirror_marker(REF_AM_RAW[lane]);
    if (beat < MARKER_SYMBOLS) begin
        return mirrored[beat*SYMBOL_WIDTH +: SYMBOL_WIDTH];
    end
    return {SYMBOL_WIDTH{1'b1}};
endfunction

function automatic aui_beat_t expected_beat(input int beat);
    aui_beat_t beat_exp;
    for (int l = 0; l < NUM_LANES; l++) begin
        beat_exp.symbols[l] = expected_symbol(l, beat);
    end
    beat_exp.sync = (beat == 0);
    return beat_exp;
endfunction

`endif

/* verification/aui_am_inserter_tb.sv */
module aui_am_inserter_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import aui_params_pkg::*;
    import aui_types_pkg::*;

    `include "aui_am_model.svh"

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 4;
    localparam int          STALL_MARGIN = 12;
    localparam int unsigned RANDOM_SEED  = 32'he74d_25a6;

    typedef enum logic [1:0] {
        READY_ALWAYS,
        READY_ALTERNATE,
        READY_STALL,
        READY_RANDOM
    } ready_mode_e;

    // param is the stall length, or the percent of ready cycles
    typedef struct packed {
        ready_mode_e mode;
        logic [15:0] beats;
        logic [7:0]  param;
    } ready_pattern_t;

    localparam int NUM_PATTERNS = 6;
    localparam ready_pattern_t PATTERNS [NUM_PATTERNS] = '{
        '{READY_ALWAYS,    16'd40, 8'd0},
        '{READY_ALTERNATE, 16'd40, 8'd0},
        '{READY_STALL,     16'd24, 8'd7},
        '{READY_RANDOM,    16'd64, 8'd70},
        '{READY_RANDOM,    16'd32, 8'd25},
        '{READY_ALWAYS,    16'd32, 8'd0}
    };

    logic      clk;
    logic      rst;
    logic      i_ready;
    aui_beat_t o_beat;
    logic      o_valid;

    int          elapsed;
    int          accepted;
    int          sync_count;
    logic        first_seen;
    logic        held_pending;
    aui_beat_t   held_beat;

    aui_am_inserter uut (
        .clk     (clk),
        .rst     (rst),
        .o_beat  (o_beat),
        .o_valid (o_valid),
        .i_ready (i_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [255:0] actual,
                               input logic [255:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            abort_run();
        end
    endtask

    function automatic int total_beats();
        int sum;
        sum = 0;
        for (int p = 0; p < NUM_PATTERNS; p++) begin
            sum += PATTERNS[p].beats;
        end
        return sum;
    endfunction

    function automatic logic ready_for(input ready_pattern_t pat, input int cycle);
        case (pat.mode)
            READY_ALWAYS:    return 1'b1;
            READY_ALTERNATE: return cycle[0];
            READY_STALL:     return (cycle % (pat.param + 1)) == pat.param;
            default:         return $urandom_range(99, 0) < pat.param;
        endcase
    endfunction

    // Called each falling edge, after i_ready has been driven
    task automatic monitor_stream();
        aui_beat_t exp_beat;
        if (elapsed == 1) begin
            check_value("o_valid", o_valid, 1'b0);
        end
        // Two stages in flight keep the output full from the first beat on
        if (first_seen) begin
            check_value("o_valid", o_valid, 1'b1);
        end else if (o_valid) begin
            first_seen = 1'b1;
            if (elapsed > 3) begin
                $display("First beat came %0d cycles after reset release", elapsed);
                abort_run();
            end
        end
        // Stalled beat must still be there
        if (held_pending) begin
            check_value("o_beat", o_beat, held_beat);
        end
        held_pending = o_valid && !i_ready;
        held_beat    = o_beat;
        if (o_valid && i_ready) begin
            exp_beat = expected_beat(accepted % FRAME_BEATS);
            check_value("o_beat.sync", o_beat.sync, exp_beat.sync);
            for (int l = 0; l < NUM_LANES; l++) begin
                check_value($sformatf("o_beat.symbols[%0d]", l),
                            o_beat.symbols[l], exp_beat.symbols[l]);
            end
            if (o_beat.sync) begin
                sync_count++;
            end
            accepted++;
        end
    endtask

    initial begin
        int start;
        int cycle;
        clk          = 1'b0;
        rst          = 1'b1;
        i_ready      = 1'b0;
        elapsed      = 0;
        accepted     = 0;
        sync_count   = 0;
        first_seen   = 1'b0;
        held_pending = 1'b0;
        void'($urandom(RANDOM_SEED));

        repeat (RESET_CYCLES) @(negedge clk);
        check_value("o_valid", o_valid, 1'b0);
        rst = 1'b0;

        for (int p = 0; p < NUM_PATTERNS; p++) begin
            start = accepted;
            cycle = 0;
            while (accepted - start < PATTERNS[p].beats) begin
                @(negedge clk);
                elapsed++;
                i_ready = ready_for(PATTERNS[p], cycle);
                cycle++;
                monitor_stream();
            end
        end

        @(negedge clk);
        i_ready = 1'b0;

        // Frame starts seen over the whole run
        if (sync_count < 3) begin
            $display("Only %0d frames were seen, at least three are needed", sync_count);
            abort_run();
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

    initial begin
        longint limit;
        limit = RESET_CYCLES + 4 + longint'(total_beats()) * STALL_MARGIN;
        #(limit * CLK_PERIOD);
        $display("No beat arrived in time, watchdog expired after %0d cycles", limit);
        abort_run();
    end

endmodule

/* sources.f */
+incdir+verification
src/aui_params_pkg.sv
src/aui_types_pkg.sv
src/am_table.sv
src/frame_sequencer.sv
src/lane_formatter.sv
src/aui_am_inserter.sv
verification/aui_am_inserter_tb.sv

/* Bender.yml */
package:
  name: aui_am_inserter

sources:
  - src/aui_params_pkg.sv
  - src/aui_types_pkg.sv
  - src/am_table.sv
  - src/frame_sequencer.sv
  - src/lane_formatter.sv
  - src/aui_am_inserter.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/aui_am_inserter_tb.sv
